/* hdl/dmem_pkg.sv */
// ----------------------------
// Shared sizes and types for the data memory stage.
// Every RAM, I/O and pipeline block refers to these by scoped name.
// ----------------------------

package dmem_pkg;

    // ----------------------------
    // Sizes
    // ----------------------------

    // One machine word, as seen by the processor datapath
    localparam int word_width = 16;

    // Word address, covering the RAM and the I/O window at its top
    localparam int addr_width = 10;
    localparam int mem_depth = 1024;

    // The I/O window is a handful of words selected by the low address bits
    localparam int io_port_count = 4;
    localparam int io_port_addr_width = 2;

    // ----------------------------
    // Types
    // ----------------------------

    typedef logic [word_width-1:0] word_t;
    typedef logic [addr_width-1:0] addr_t;

    // One strobe bit per I/O port
    typedef logic [io_port_count-1:0] io_mask_t;

    // One word per I/O port, port 0 in the lowest slot
    typedef logic [io_port_count-1:0][word_width-1:0] io_words_t;

    // First address of the I/O window
    // A port index is the address minus this base
    localparam addr_t io_port_base_addr = addr_t'(1020);

endpackage

/* hdl/dmem_write_if.sv */
// ----------------------------
// Registered write bundle from the first write stage.
// The write stage drives it, the RAM and the I/O ports listen.
// ----------------------------

`timescale 1ns/1ps

interface dmem_write_if;

    // RAM write enable, never active together with an I/O strobe
    logic mem_wren;

    // One strobe per I/O port, at most one bit set
    dmem_pkg::io_mask_t io_wren;

    // Target address and word, shared by the RAM and the I/O ports
    dmem_pkg::addr_t addr;
    dmem_pkg::word_t data;

    // The write stage owns every field
    modport source (
        output mem_wren,
        output io_wren,
        output addr,
        output data
    );

    // Consumers only read the bundle
    modport sink (
        input mem_wren,
        input io_wren,
        input addr,
        input data
    );

endinterface

/* hdl/dmem_ram.sv */
// ----------------------------
// Simple dual-port data RAM with one write and one registered read port.
// A read that hits the word being written returns the new word.
// ----------------------------

`timescale 1ns/1ps

module dmem_ram (
    input  logic                 clock,
    dmem_write_if.sink           sink,
    input  logic                 rden,
    input  dmem_pkg::addr_t      read_addr,
    output dmem_pkg::word_t      mem_read_data
);

    // Contents start undefined and are never cleared
    dmem_pkg::word_t mem [dmem_pkg::mem_depth];

    // ----------------------------
    // Write port
    // ----------------------------

    // The bundle is already gated, so mem_wren alone decides the write
    always_ff @(posedge clock) begin
        if (sink.mem_wren) begin
            mem[sink.addr] <= sink.data;
        end
    end

    // ----------------------------
    // Read port
    // ----------------------------

    // The read data register only loads when rden is high and holds otherwise
    // A write to the same address on the same edge is forwarded to the output
    always_ff @(posedge clock) begin
        if (rden) begin
            if (sink.mem_wren && (sink.addr == read_addr)) begin
                mem_read_data <= sink.data;
            end else begin
                mem_read_data <= mem[read_addr];
            end
        end
    end

    // ----------------------------
    // Checks
    // ----------------------------

    // The write stage must never target the RAM and an I/O port at once
    // Before reset the enable is unknown and the check passes vacuously
    write_target_exclusive: assert property (
        @(posedge clock) sink.mem_wren |-> (sink.io_wren == '0)
    ) else $error("RAM write and I/O write strobe active together");

endmodule

/* hdl/dmem_read_stage.sv */
// ----------------------------
// Two-stage read pipeline of the data memory.
// Stage 1 starts the RAM read and captures the I/O word, stage 2 picks
// one of them and clears it when the read was not enabled.
// ----------------------------

`timescale 1ns/1ps

module dmem_read_stage (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  ior,
    input  logic                  cancel,
    input  logic                  read_enable,
    input  logic                  read_addr_is_io,
    input  dmem_pkg::addr_t       read_addr,
    input  dmem_pkg::io_words_t   io_read_data,
    output logic                  rden,
    input  dmem_pkg::word_t       mem_read_data,
    output dmem_pkg::word_t       read_data
);

    dmem_pkg::addr_t                            io_offset;
    logic [dmem_pkg::io_port_addr_width-1:0]    io_index;
    logic                                       read_enable_combined;
    dmem_pkg::word_t                            io_read_data_selected;
    logic                                       read_enable_stage2;
    logic                                       read_addr_is_io_stage2;
    dmem_pkg::word_t                            read_data_raw;

    // ----------------------------
    // Stage 1
    // ----------------------------

    // The RAM read is only turned off for I/O addresses
    // Decoding the full enable here would lengthen the address path, so
    // disabled reads are cleared in stage 2 instead
    assign rden = !read_addr_is_io;

    // The port index is the offset into the I/O window
    // Only its low bits matter, the flag from the previous stage says
    // whether the address really is in the window
    assign io_offset = read_addr - dmem_pkg::io_port_base_addr;
    assign io_index = io_offset[dmem_pkg::io_port_addr_width-1:0];

    // A read counts only for a live instruction that asked for it
    assign read_enable_combined = read_enable && ior && !cancel;

    // The I/O word is sampled on the same edge that the RAM takes the address,
    // so both sources line up for stage 2
    always_ff @(posedge clock) begin
        io_read_data_selected <= io_read_data[io_index];
    end

    // Control travels alongside the data into stage 2
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            read_enable_stage2 <= 1'b0;
            read_addr_is_io_stage2 <= 1'b0;
        end else begin
            read_enable_stage2 <= read_enable_combined;
            read_addr_is_io_stage2 <= read_addr_is_io;
        end
    end

    // ----------------------------
    // Stage 2
    // ----------------------------

    // Choose between the captured I/O word and the RAM output,
    // then force zero for a disabled, annulled or cancelled read
    always_comb begin
        if (!read_enable_stage2) begin
            read_data_raw = '0;
        end else if (read_addr_is_io_stage2) begin
            read_data_raw = io_read_data_selected;
        end else begin
            read_data_raw = mem_read_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            read_data <= '0;
        end else begin
            read_data <= read_data_raw;
        end
    end

    // ----------------------------
    // Checks
    // ----------------------------

    // Whatever the RAM happens to hold, a read that was not enabled
    // must come out as zero on the next edge
    disabled_read_is_zero: assert property (
        @(posedge clock) disable iff (!rst_n)
        !read_enable_stage2 |=> (read_data == '0)
    ) else $error("Disabled read returned nonzero data");

endmodule

/* hdl/dmem_write_stage.sv */
// ----------------------------
// First write stage of the data memory.
// Gates the write with the previous instruction's status, splits it into
// a RAM or an I/O write and registers the result onto the write bundle.
// ----------------------------

`timescale 1ns/1ps

module dmem_write_stage (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               ior_previous,
    input  logic               cancel_previous,
    input  logic               write_enable,
    input  logic               write_addr_is_io,
    input  dmem_pkg::addr_t    write_addr,
    input  dmem_pkg::word_t    write_data,
    dmem_write_if.source       source
);

    logic                                       write_enable_gated;
    dmem_pkg::addr_t                            io_offset;
    logic [dmem_pkg::io_port_addr_width-1:0]    io_index;
    dmem_pkg::io_mask_t                         io_wren_raw;
    logic                                       mem_wren_raw;

    // ----------------------------
    // Enable and decode
    // ----------------------------

    // The write belongs to the previous instruction, so its annul and
    // cancel flags decide whether the write happens at all
    assign write_enable_gated = write_enable && ior_previous && !cancel_previous;

    // Port index is the offset into the I/O window
    assign io_offset = write_addr - dmem_pkg::io_port_base_addr;
    assign io_index = io_offset[dmem_pkg::io_port_addr_width-1:0];

    // An I/O write sets exactly one strobe bit
    // A RAM write takes every address outside the I/O window, which also
    // keeps the RAM from burning power on I/O accesses
    always_comb begin
        io_wren_raw = '0;
        mem_wren_raw = 1'b0;
        if (write_enable_gated) begin
            if (write_addr_is_io) begin
                io_wren_raw = dmem_pkg::io_mask_t'(1) << io_index;
            end else begin
                mem_wren_raw = 1'b1;
            end
        end
    end

    // ----------------------------
    // Bundle registers
    // ----------------------------

    // Enables are control state and clear on reset
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            source.mem_wren <= 1'b0;
            source.io_wren <= '0;
        end else begin
            source.mem_wren <= mem_wren_raw;
            source.io_wren <= io_wren_raw;
        end
    end

    // Address and data only matter when an enable is set
    always_ff @(posedge clock) begin
        source.addr <= write_addr;
        source.data <= write_data;
    end

    // ----------------------------
    // Checks
    // ----------------------------

    // The decode must never address two I/O ports at once
    io_strobe_onehot: assert property (
        @(posedge clock) disable iff (!rst_n)
        $onehot0(source.io_wren)
    ) else $error("More than one I/O write strobe set");

endmodule

/* hdl/dmem_io_ports.sv */
// ----------------------------
// Second write stage for the memory-mapped I/O ports.
// Drives the per-port write strobes and holds the last word written
// to each port.
// ----------------------------

`timescale 1ns/1ps

module dmem_io_ports (
    input  logic                   clock,
    input  logic                   rst_n,
    dmem_write_if.sink             sink,
    output dmem_pkg::io_mask_t     io_wren,
    output dmem_pkg::io_words_t    io_write_data
);

    // ----------------------------
    // Write strobes
    // ----------------------------

    // The strobe leaves on the same edge that loads the port word,
    // so a device sees it together with the new value
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            io_wren <= '0;
        end else begin
            io_wren <= sink.io_wren;
        end
    end

    // ----------------------------
    // Held output words
    // ----------------------------

    // Each slot loads the bundle word only when its own strobe is set
    // At most one strobe is set, so the bundle word can feed every slot
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            io_write_data <= '0;
        end else begin
            for (int port = 0; port < dmem_pkg::io_port_count; port++) begin
                if (sink.io_wren[port]) begin
                    io_write_data[port] <= sink.data;
                end
            end
        end
    end

endmodule

/* hdl/data_memory.sv */
// ----------------------------
// Data memory stage of the soft processor.
// Word-addressed RAM with memory-mapped I/O ports at the top of the
// address range and separate read and write address paths.
// Reads return two edges after sampling, writes land one edge later.
// ----------------------------

`timescale 1ns/1ps

module data_memory (
    input  logic                   clock,
    input  logic                   rst_n,

    // Status of the current (read) and previous (write) instruction
    input  logic                   ior,
    input  logic                   cancel,
    input  logic                   ior_previous,
    input  logic                   cancel_previous,

    // Read path
    // The I/O flag is decoded by the stage before this one
    input  logic                   read_enable,
    input  dmem_pkg::addr_t        read_addr,
    input  logic                   read_addr_is_io,
    output dmem_pkg::word_t        read_data,
    input  dmem_pkg::io_words_t    io_read_data,

    // Write path
    input  logic                   write_enable,
    input  dmem_pkg::addr_t        write_addr,
    input  logic                   write_addr_is_io,
    input  dmem_pkg::word_t        write_data,
    output dmem_pkg::io_mask_t     io_wren,
    output dmem_pkg::io_words_t    io_write_data
);

    // RAM read handshake between the read stage and the RAM
    logic              rden;
    dmem_pkg::word_t   mem_read_data;

    // Registered write bundle
    dmem_write_if write_bus ();

    // ----------------------------
    // Read side
    // ----------------------------

    dmem_read_stage read_stage_inst (
        .clock           (clock),
        .rst_n           (rst_n),
        .ior             (ior),
        .cancel          (cancel),
        .read_enable     (read_enable),
        .read_addr_is_io (read_addr_is_io),
        .read_addr       (read_addr),
        .io_read_data    (io_read_data),
        .rden            (rden),
        .mem_read_data   (mem_read_data),
        .read_data       (read_data)
    );

    dmem_ram ram_inst (
        .clock         (clock),
        .sink          (write_bus.sink),
        .rden          (rden),
        .read_addr     (read_addr),
        .mem_read_data (mem_read_data)
    );

    // ----------------------------
    // Write side
    // ----------------------------

    dmem_write_stage write_stage_inst (
        .clock            (clock),
        .rst_n            (rst_n),
        .ior_previous     (ior_previous),
        .cancel_previous  (cancel_previous),
        .write_enable     (write_enable),
        .write_addr_is_io (write_addr_is_io),
        .write_addr       (write_addr),
        .write_data       (write_data),
        .source           (write_bus.source)
    );

    dmem_io_ports io_ports_inst (
        .clock         (clock),
        .rst_n         (rst_n),
        .sink          (write_bus.sink),
        .io_wren       (io_wren),
        .io_write_data (io_write_data)
    );

endmodule

/* verif/data_memory_tb.sv */
// ----------------------------
// Self-checking testbench for the data memory stage.
// Drives RAM and I/O traffic from an LFSR and compares read_data, io_wren
// and io_write_data against a reference model two edges after each edge.
// ----------------------------

`timescale 1ns/1ps

module data_memory_tb;

    localparam int half_period = 4;
    localparam int drive_delay = 1;
    localparam int reset_cycles = 10;
    localparam int wait_limit = 100;
    localparam int run_limit_ns = 20000;
    localparam logic [15:0] lfsr_seed = 16'd45808;

    logic clock = 1'b0;
    logic rst_n = 1'b0;
    logic ior, cancel, ior_previous, cancel_previous;
    logic read_enable, read_addr_is_io, write_enable, write_addr_is_io;
    dmem_pkg::addr_t read_addr, write_addr;
    dmem_pkg::word_t read_data, write_data;
    dmem_pkg::io_words_t io_read_data, io_write_data;
    dmem_pkg::io_mask_t io_wren;

    // Reference model state and the expectations still in flight
    dmem_pkg::word_t ram_model [dmem_pkg::mem_depth];
    dmem_pkg::io_words_t io_model;
    dmem_pkg::word_t read_queue [$];
    dmem_pkg::io_mask_t wren_queue [$];
    dmem_pkg::io_words_t io_data_queue [$];
    dmem_pkg::addr_t written_addrs [$];
    logic [15:0] lfsr_state = lfsr_seed;
    int error_count = 0;
    int pushed_count = 0;
    int checked_count = 0;

    always #(half_period) clock = ~clock;

    data_memory data_memory_inst (.*);

    // Fibonacci LFSR with taps 16, 14, 13 and 11, stepped once per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] bits;
        logic feedback;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], feedback};
            bits = {bits[30:0], feedback};
        end
        return bits;
    endfunction

    // Any word address below the I/O window
    function automatic dmem_pkg::addr_t random_ram_addr();
        return dmem_pkg::addr_t'(random_bits(10) % dmem_pkg::io_port_base_addr);
    endfunction

    function automatic dmem_pkg::addr_t io_addr(input int port);
        return dmem_pkg::io_port_base_addr + dmem_pkg::addr_t'(port);
    endfunction

    // Expected read result for the controls sampled on the read's first edge
    // A RAM write sampled one edge earlier is already in ram_model, which
    // matches the RAM's same-edge forwarding
    function automatic dmem_pkg::word_t expected_read(input logic enable, input logic live,
            input logic cancelled, input logic is_io, input dmem_pkg::addr_t addr);
        dmem_pkg::addr_t offset;
        offset = addr - dmem_pkg::io_port_base_addr;
        if (!(enable && live && !cancelled)) begin
            return '0;
        end
        if (is_io) begin
            return io_read_data[offset[dmem_pkg::io_port_addr_width-1:0]];
        end
        return ram_model[addr];
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] expected,
            input logic [63:0] actual);
        $display("FAIL %s expected %h got %h", name, expected, actual);
        error_count++;
    endtask

    task automatic print_counts();
        $display("Checked %0d cycles, %0d errors", checked_count, error_count);
    endtask

    task automatic finish_run();
        print_counts();
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        print_counts();
        $display("Simulation failed");
        $finish;
    endtask

    // ----------------------------
    // Model update and comparison
    // ----------------------------

    // Runs on each active edge, reads first, then applies this edge's write
    task automatic sample_edge();
        dmem_pkg::addr_t offset;
        dmem_pkg::io_mask_t mask;
        mask = '0;
        read_queue.push_back(expected_read(read_enable, ior, cancel, read_addr_is_io, read_addr));
        if (write_enable && ior_previous && !cancel_previous) begin
            if (write_addr_is_io) begin
                offset = write_addr - dmem_pkg::io_port_base_addr;
                mask[offset[dmem_pkg::io_port_addr_width-1:0]] = 1'b1;
                io_model[offset[dmem_pkg::io_port_addr_width-1:0]] = write_data;
            end else begin
                ram_model[write_addr] = write_data;
            end
        end
        wren_queue.push_back(mask);
        io_data_queue.push_back(io_model);
        pushed_count++;
    endtask

    // Results of the edge two edges back are stable at the falling edge
    task automatic check_outputs();
        dmem_pkg::word_t exp_read;
        dmem_pkg::io_mask_t exp_wren;
        dmem_pkg::io_words_t exp_io;
        if (read_queue.size() == 2) begin
            exp_read = read_queue.pop_front();
            exp_wren = wren_queue.pop_front();
            exp_io = io_data_queue.pop_front();
            if (read_data !== exp_read) begin
                report_mismatch("read_data", exp_read, read_data);
            end
            if (io_wren !== exp_wren) begin
                report_mismatch("io_wren", exp_wren, io_wren);
            end
            if (io_write_data !== exp_io) begin
                report_mismatch("io_write_data", exp_io, io_write_data);
            end
            checked_count++;
        end
    endtask

    initial begin : compare
        int wait_cycles;
        wait_cycles = 0;
        while (rst_n !== 1'b1 && wait_cycles < wait_limit) begin
            @(posedge clock);
            wait_cycles++;
        end
        if (rst_n !== 1'b1) begin
            abort_run("Reset was never released");
        end else begin
            forever begin
                sample_edge();
                @(negedge clock);
                check_outputs();
                @(posedge clock);
            end
        end
    end

    initial begin : watchdog
        #(run_limit_ns);
        abort_run("Simulation ran past its time limit");
    end

    // ----------------------------
    // Stimulus
    // ----------------------------

    // Every cycle starts idle with a live current and previous instruction
    task automatic advance();
        @(posedge clock);
        #(drive_delay);
        read_enable = 1'b0;
        write_enable = 1'b0;
        read_addr_is_io = 1'b0;
        write_addr_is_io = 1'b0;
        ior = 1'b1;
        cancel = 1'b0;
        ior_previous = 1'b1;
        cancel_previous = 1'b0;
    endtask

    task automatic set_read(input logic is_io, input dmem_pkg::addr_t addr);
        read_enable = 1'b1;
        read_addr_is_io = is_io;
        read_addr = addr;
    endtask

    task automatic set_write(input logic is_io, input dmem_pkg::addr_t addr,
            input dmem_pkg::word_t data);
        write_enable = 1'b1;
        write_addr_is_io = is_io;
        write_addr = addr;
        write_data = data;
    endtask

    function automatic dmem_pkg::addr_t pick_written();
        return written_addrs[random_bits(8) % written_addrs.size()];
    endfunction

    initial begin : stimulus
        dmem_pkg::addr_t addr;
        int port;
        int target;
        int wait_cycles;
        {ior, cancel, ior_previous, cancel_previous} = '0;
        {read_enable, read_addr_is_io, write_enable, write_addr_is_io} = '0;
        read_addr = '0;
        write_addr = '0;
        write_data = '0;
        io_read_data = '0;
        io_model = '0;
        repeat (reset_cycles) @(posedge clock);
        #(drive_delay);
        if (read_data !== '0) report_mismatch("read_data", '0, read_data);
        if (io_wren !== '0) report_mismatch("io_wren", '0, io_wren);
        if (io_write_data !== '0) report_mismatch("io_write_data", '0, io_write_data);
        rst_n = 1'b1;

        // RAM writes, the last one read back on the next cycle via forwarding
        for (int i = 0; i < 16; i++) begin
            advance();
            addr = random_ram_addr();
            set_write(1'b0, addr, random_bits(16));
            written_addrs.push_back(addr);
        end
        advance();
        set_read(1'b0, addr);
        foreach (written_addrs[i]) begin
            advance();
            set_read(1'b0, written_addrs[i]);
        end

        // Disabled, annulled and cancelled reads on RAM and I/O addresses
        // The port words are live here, so an unmasked I/O read would show
        for (int i = 0; i < 12; i++) begin
            advance();
            io_read_data = {random_bits(32), random_bits(32)};
            if (random_bits(1)) begin
                set_read(1'b1, io_addr(random_bits(2)));
            end else begin
                set_read(1'b0, pick_written());
            end
            case (i % 3)
                0: read_enable = 1'b0;
                1: ior = 1'b0;
                default: cancel = 1'b1;
            endcase
        end

        // I/O reads, with the port words changing every cycle
        for (int i = 0; i < 8; i++) begin
            advance();
            io_read_data = {random_bits(32), random_bits(32)};
            set_read(1'b1, io_addr(random_bits(2)));
        end

        // RAM word under an I/O address, I/O write, then the RAM word again
        for (int i = 0; i < 6; i++) begin
            port = random_bits(2);
            advance();
            set_write(1'b0, io_addr(port), random_bits(16));
            written_addrs.push_back(io_addr(port));
            advance();
            set_write(1'b1, io_addr(port), random_bits(16));
            advance();
            set_read(1'b0, io_addr(port));
        end

        // Blocked writes must leave RAM and I/O words untouched
        for (int i = 0; i < 12; i++) begin
            advance();
            if (random_bits(1)) begin
                set_write(1'b1, io_addr(random_bits(2)), random_bits(16));
            end else begin
                set_write(1'b0, pick_written(), random_bits(16));
            end
            case (i % 3)
                0: write_enable = 1'b0;
                1: ior_previous = 1'b0;
                default: cancel_previous = 1'b1;
            endcase
        end
        foreach (written_addrs[i]) begin
            advance();
            set_read(1'b0, written_addrs[i]);
        end

        // Let the last operation come out of the pipeline
        advance();
        target = pushed_count;
        wait_cycles = 0;
        while (checked_count < target && wait_cycles < wait_limit) begin
            @(posedge clock);
            wait_cycles++;
        end
        if (checked_count < target) begin
            abort_run("Timed out waiting for the last results to be checked");
        end else begin
            finish_run();
        end
    end

endmodule

/* compile.f */
hdl/dmem_pkg.sv
hdl/dmem_write_if.sv
hdl/dmem_ram.sv
hdl/dmem_read_stage.sv
hdl/dmem_write_stage.sv
hdl/dmem_io_ports.sv
hdl/data_memory.sv
verif/data_memory_tb.sv
